//--- hdl/crc32_calc.sv
`timescale 1ns/10ps
`default_nettype none

module crc32_calc (
    input  logic        clk,
    input  logic        reset,
    input  logic        update,
    input  logic [7:0]  data,
    input  logic        valid,
    output logic [31:0] crc
);

    logic [31:0] crc_reg;
    logic [31:0] crc_next;

    // restart from all ones when update is low, then fold lsb first
    always_comb begin
        crc_next = update ? crc_reg : 32'hffffffff;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data[i]) begin
                crc_next = (crc_next >> 1) ^ ring_pkg::CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crc_reg <= 32'hffffffff;
        end else if (valid) begin
            crc_reg <= crc_next;
        end
    end

    // output is the inverted register, as sent in the FCS
    assign crc = ~crc_reg;

endmodule

`default_nettype wire

//--- hdl/data_delay.sv
`timescale 1ns/10ps
`default_nettype none

module data_delay (
    input  logic        clk,
    input  logic        reset,
    input  logic [13:0] in_data,
    input  logic        in_valid,
    output logic [13:0] out_data,
    output logic        out_valid
);

    logic [13:0]                         data_q [ring_pkg::REPLACE_DELAY];
    logic [ring_pkg::REPLACE_DELAY-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < ring_pkg::REPLACE_DELAY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // data shifts every cycle, valid or not
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < ring_pkg::REPLACE_DELAY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_data  = data_q[ring_pkg::REPLACE_DELAY-1];
    assign out_valid = valid_q[ring_pkg::REPLACE_DELAY-1];

endmodule

`default_nettype wire

//--- hdl/packet_rx.sv
`timescale 1ns/10ps
`default_nettype none

module packet_rx (
    input  logic        clk,
    input  logic        reset,

    input  logic        rx_first,
    input  logic        rx_last,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,

    output logic        fw_first,
    output logic        fw_last,
    output logic [7:0]  fw_data,
    output logic        fw_valid,

    output logic        rx_start,
    output logic        rx_end,
    output logic        rx_error,

    output logic [15:0] rx_length,
    output logic [7:0]  rx_type,
    output logic [7:0]  rx_node,

    output logic        payload_first,
    output logic        payload_last,
    output logic [15:0] payload_pos,
    output logic [7:0]  payload_data,
    output logic        payload_valid,

    input  logic [7:0]  replace_data,
    input  logic        replace_valid
);

    ring_pkg::rx_state_t state;

    logic [3:0]  cnt;
    logic        fcs_rx_last;
    logic        crc_update;
    logic        crc_check;
    logic [31:0] crc_value;
    logic [15:0] payload_pos_next;
    logic [7:0]  preamble_expect;
    logic        frame_err;

    // parser stage of the forward path
    logic [1:0]  pk_count;
    logic        pk_crc_update;
    logic        pk_fcs;
    logic        pk_first;
    logic        pk_last;
    logic [7:0]  pk_data;
    logic        pk_valid;

    assign payload_pos_next = payload_pos + 16'd1;
    assign preamble_expect  = (cnt == 4'd6) ? ring_pkg::SFD_BYTE : ring_pkg::PREAMBLE_BYTE;

    // first inside a frame, last outside the FCS, or a bad preamble byte
    assign frame_err =
        (rx_first && state != ring_pkg::IDLE && state != ring_pkg::ERROR) ||
        (rx_last && !rx_first && !fcs_rx_last &&
            state != ring_pkg::IDLE && state != ring_pkg::ERROR) ||
        (state == ring_pkg::PREAMBLE && rx_data != preamble_expect);

    // --------------------
    // parser
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ring_pkg::IDLE;
            cnt           <= 4'd0;
            fcs_rx_last   <= 1'b0;
            crc_update    <= 1'b0;
            crc_check     <= 1'b0;
            payload_first <= 1'b0;
            payload_last  <= 1'b0;
            payload_pos   <= 16'd0;
            rx_start      <= 1'b0;
            rx_end        <= 1'b0;
            rx_error      <= 1'b0;
            pk_valid      <= 1'b0;
        end else begin
            rx_start  <= 1'b0;
            rx_end    <= 1'b0;
            rx_error  <= 1'b0;
            crc_check <= 1'b0;
            pk_valid  <= 1'b0;

            if (rx_valid) begin
                pk_count      <= cnt[1:0];
                pk_crc_update <= crc_update;
                pk_fcs        <= (state == ring_pkg::FCS);
                pk_first      <= rx_first;
                pk_last       <= rx_last;
                pk_data       <= rx_data;
                pk_valid      <= 1'b1;

                if (cnt != 4'hf) begin
                    cnt <= cnt + 4'd1;
                end

                payload_first <= 1'b0;
                payload_last  <= 1'b0;
                fcs_rx_last   <= 1'b0;

                case (state)
                    ring_pkg::IDLE: begin
                        // only a good frame start is forwarded
                        pk_valid <= 1'b0;
                        if (rx_first) begin
                            if (rx_data == ring_pkg::PREAMBLE_BYTE && !rx_last) begin
                                state    <= ring_pkg::PREAMBLE;
                                rx_start <= 1'b1;
                                cnt      <= 4'd0;
                                pk_valid <= 1'b1;
                            end else begin
                                state    <= ring_pkg::ERROR;
                                rx_error <= 1'b1;
                            end
                        end
                    end

                    ring_pkg::PREAMBLE: begin
                        if (cnt == 4'd6) begin
                            state      <= ring_pkg::LENGTH;
                            cnt        <= 4'd0;
                            crc_update <= 1'b0;
                        end
                    end

                    ring_pkg::LENGTH: begin
                        crc_update <= 1'b1;
                        if (cnt[0]) begin
                            rx_length[15:8] <= rx_data;
                            state           <= ring_pkg::TYPE;
                        end else begin
                            rx_length[7:0] <= rx_data;
                        end
                    end

                    ring_pkg::TYPE: begin
                        rx_type <= rx_data;
                        state   <= ring_pkg::NODE;
                    end

                    ring_pkg::NODE: begin
                        rx_node       <= rx_data;
                        state         <= ring_pkg::PAYLOAD;
                        payload_first <= 1'b1;
                        payload_last  <= (rx_length == 16'd0);
                        payload_pos   <= 16'd0;
                        // up-stream hop count
                        pk_data       <= rx_data + 8'd1;
                    end

                    ring_pkg::PAYLOAD: begin
                        payload_last <= (payload_pos_next == rx_length);
                        payload_pos  <= payload_pos_next;
                        if (payload_last) begin
                            state <= ring_pkg::FCS;
                            cnt   <= 4'd0;
                        end
                    end

                    ring_pkg::FCS: begin
                        fcs_rx_last <= (cnt[1:0] == 2'd2);
                        if (fcs_rx_last) begin
                            state     <= ring_pkg::IDLE;
                            crc_check <= 1'b1;
                        end
                    end

                    default: begin
                        state <= ring_pkg::IDLE;
                    end
                endcase

                // cut the forwarded frame with a zero byte
                if (frame_err) begin
                    state    <= ring_pkg::ERROR;
                    rx_error <= 1'b1;
                    pk_fcs   <= 1'b0;
                    pk_first <= 1'b0;
                    pk_last  <= 1'b1;
                    pk_data  <= 8'h00;
                    pk_valid <= 1'b1;
                end
            end

            if (state == ring_pkg::ERROR) begin
                state    <= ring_pkg::IDLE;
                pk_valid <= 1'b0;
            end

            if (crc_check) begin
                if (crc_value == ring_pkg::CRC_RESIDUE) begin
                    rx_end <= 1'b1;
                end else begin
                    rx_error <= 1'b1;
                end
            end
        end
    end

    assign payload_data  = rx_data;
    assign payload_valid = rx_valid & (state == ring_pkg::PAYLOAD);

    // residue check runs over the received bytes including the FCS
    crc32_calc crc_rx (
        .clk    (clk),
        .reset  (reset),
        .update (crc_update),
        .data   (rx_data),
        .valid  (rx_valid),
        .crc    (crc_value)
    );

    // --------------------
    // forward path
    // --------------------
    logic [1:0]  dly_count;
    logic        dly_crc_update;
    logic        dly_fcs;
    logic        dly_first;
    logic        dly_last;
    logic [7:0]  dly_data_raw;
    logic [7:0]  dly_data;
    logic        dly_valid;
    logic [31:0] fw_crc;

    data_delay delay0 (
        .clk       (clk),
        .reset     (reset),
        .in_data   ({pk_count, pk_crc_update, pk_fcs, pk_first, pk_last, pk_data}),
        .in_valid  (pk_valid),
        .out_data  ({dly_count, dly_crc_update, dly_fcs, dly_first, dly_last, dly_data_raw}),
        .out_valid (dly_valid)
    );

    assign dly_data = replace_valid ? replace_data : dly_data_raw;

    // received FCS bytes are not folded, the register keeps the new CRC
    crc32_calc crc_fw (
        .clk    (clk),
        .reset  (reset),
        .update (dly_crc_update),
        .data   (dly_data),
        .valid  (dly_valid & ~dly_fcs),
        .crc    (fw_crc)
    );

    logic [1:0] out_count;
    logic       out_fcs;
    logic [7:0] out_buf;

    always_ff @(posedge clk) begin
        if (reset) begin
            fw_valid <= 1'b0;
        end else begin
            fw_valid <= dly_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_count <= dly_count;
        out_fcs   <= dly_fcs;
        fw_first  <= dly_first;
        fw_last   <= dly_last;
        out_buf   <= dly_data;
    end

    // FCS goes out low byte first
    assign fw_data = out_fcs ? fw_crc[out_count*8 +: 8] : out_buf;

endmodule

`default_nettype wire

//--- hdl/ring_node.sv
`timescale 1ns/10ps
`default_nettype none

module ring_node (
    input  logic        clk,
    input  logic        reset,

    input  logic        rx_first,
    input  logic        rx_last,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,

    output logic        tx_first,
    output logic        tx_last,
    output logic [7:0]  tx_data,
    output logic        tx_valid,

    output logic        rx_start,
    output logic        rx_end,
    output logic        rx_error,
    output logic [15:0] rx_length,
    output logic [7:0]  rx_type,
    output logic [7:0]  rx_node,

    output logic        payload_first,
    output logic        payload_last,
    output logic [15:0] payload_pos,
    output logic [7:0]  payload_data,
    output logic        payload_valid,

    input  logic [15:0] slot_pos,
    input  logic [7:0]  slot_tx_data,
    output logic [7:0]  slot_rx_data,
    output logic        slot_rx_valid
);

    logic       fw_first;
    logic       fw_last;
    logic [7:0] fw_data;
    logic       fw_valid;
    logic [7:0] replace_data;
    logic       replace_valid;

    packet_rx rx0 (
        .clk           (clk),
        .reset         (reset),
        .rx_first      (rx_first),
        .rx_last       (rx_last),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .fw_first      (fw_first),
        .fw_last       (fw_last),
        .fw_data       (fw_data),
        .fw_valid      (fw_valid),
        .rx_start      (rx_start),
        .rx_end        (rx_end),
        .rx_error      (rx_error),
        .rx_length     (rx_length),
        .rx_type       (rx_type),
        .rx_node       (rx_node),
        .payload_first (payload_first),
        .payload_last  (payload_last),
        .payload_pos   (payload_pos),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .replace_data  (replace_data),
        .replace_valid (replace_valid)
    );

    slot_exchange slot0 (
        .clk           (clk),
        .reset         (reset),
        .payload_pos   (payload_pos),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .slot_pos      (slot_pos),
        .slot_tx_data  (slot_tx_data),
        .slot_rx_data  (slot_rx_data),
        .slot_rx_valid (slot_rx_valid),
        .replace_data  (replace_data),
        .replace_valid (replace_valid)
    );

    tx_buffer buf0 (
        .clk       (clk),
        .reset     (reset),
        .in_first  (fw_first),
        .in_last   (fw_last),
        .in_data   (fw_data),
        .in_valid  (fw_valid),
        .out_first (tx_first),
        .out_last  (tx_last),
        .out_data  (tx_data),
        .out_valid (tx_valid)
    );

endmodule

`default_nettype wire

//--- hdl/ring_pkg.sv
`default_nettype none

package ring_pkg;

    // --------------------
    // frame constants
    // --------------------
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;

    // reflected form of 0x04c11db7
    localparam logic [31:0] CRC_POLY = 32'hedb88320;

    // inverted register value after a good frame plus its FCS
    localparam logic [31:0] CRC_RESIDUE = 32'h2144df1c;

    // cycles between the parser stage and the replace point
    localparam int unsigned REPLACE_DELAY = 2;

    // --------------------
    // receive states
    // --------------------
    typedef enum logic [6:0] {
        IDLE     = 7'b0000000,
        PREAMBLE = 7'b0000001,
        LENGTH   = 7'b0000010,
        TYPE     = 7'b0000100,
        NODE     = 7'b0001000,
        PAYLOAD  = 7'b0010000,
        FCS      = 7'b0100000,
        ERROR    = 7'b1000000
    } rx_state_t;

endpackage

`default_nettype wire

//--- hdl/slot_exchange.sv
`timescale 1ns/10ps
`default_nettype none

module slot_exchange (
    input  logic        clk,
    input  logic        reset,

    input  logic [15:0] payload_pos,
    input  logic [7:0]  payload_data,
    input  logic        payload_valid,

    input  logic [15:0] slot_pos,
    input  logic [7:0]  slot_tx_data,

    output logic [7:0]  slot_rx_data,
    output logic        slot_rx_valid,

    output logic [7:0]  replace_data,
    output logic        replace_valid
);

    logic [7:0] delay_cnt;
    logic       hit;

    assign hit = payload_valid && (payload_pos == slot_pos);

    always_ff @(posedge clk) begin
        if (reset) begin
            delay_cnt     <= 8'd0;
            slot_rx_valid <= 1'b0;
            replace_valid <= 1'b0;
        end else begin
            slot_rx_valid <= 1'b0;
            replace_valid <= 1'b0;

            if (delay_cnt != 8'd0) begin
                delay_cnt <= delay_cnt - 8'd1;
            end
            // lines up with the slot byte leaving data_delay
            if (delay_cnt == 8'd1) begin
                replace_valid <= 1'b1;
            end

            if (hit) begin
                slot_rx_valid <= 1'b1;
                delay_cnt     <= 8'(ring_pkg::REPLACE_DELAY);
            end
        end
    end

    // captured bytes
    always_ff @(posedge clk) begin
        if (hit) begin
            slot_rx_data <= payload_data;
            replace_data <= slot_tx_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tx_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tx_buffer (
    input  logic       clk,
    input  logic       reset,

    input  logic       in_first,
    input  logic       in_last,
    input  logic [7:0] in_data,
    input  logic       in_valid,

    output logic       out_first,
    output logic       out_last,
    output logic [7:0] out_data,
    output logic       out_valid
);

    logic [9:0] mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] fill;
    logic       enable;

    assign out_valid = (fill != 2'd0) & enable;
    assign {out_first, out_last, out_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            fill   <= 2'd0;
            enable <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (out_valid) begin
                rd_ptr <= ~rd_ptr;
            end

            case ({in_valid, out_valid})
                2'b10:   fill <= fill + 2'd1;
                2'b01:   fill <= fill - 2'd1;
                default: fill <= fill;
            endcase

            // hold one byte, then run until the last one leaves
            if (fill != 2'd0) begin
                enable <= 1'b1;
            end
            if (out_valid && out_last) begin
                enable <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= {in_first, in_last, in_data};
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the ring node testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_ring_node -o tb_ring_node
if [ $? -ne 0 ]; then
    echo "verilator build returned an error"
    exit 1
fi

./obj_dir/tb_ring_node > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

exit 0

//--- sim.f
+incdir+sim
hdl/ring_pkg.sv
hdl/crc32_calc.sv
hdl/data_delay.sv
hdl/packet_rx.sv
hdl/slot_exchange.sv
hdl/tx_buffer.sv
hdl/ring_node.sv
sim/tb_ring_node.sv

//--- sim/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

localparam logic [31:0] TB_CRC_POLY = 32'hedb88320;

// xorshift32
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// reflected crc-32 step with the byte xored in first
function automatic logic [31:0] crc_step(logic [31:0] crc, logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'd0, b};
    for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ TB_CRC_POLY) : (c >> 1);
    end
    return c;
endfunction

// fcs covers length through payload
function automatic void append_fcs();
    logic [31:0] c;
    c = 32'hffffffff;
    for (int i = 8; i < exp_q.size(); i++) begin
        c = crc_step(c, exp_q[i]);
    end
    c = ~c;
    for (int k = 0; k < 4; k++) begin
        exp_q.push_back(c[8*k +: 8]);
    end
endfunction

function automatic void build_frame(logic [15:0] len, logic [7:0] typ, logic [7:0] node);
    logic [31:0] r;
    exp_q.delete();
    repeat (7) exp_q.push_back(8'h55);
    exp_q.push_back(8'hd5);
    exp_q.push_back(len[7:0]);
    exp_q.push_back(len[15:8]);
    exp_q.push_back(typ);
    exp_q.push_back(node);
    for (int p = 0; p <= int'(len); p++) begin
        r = next_rand();
        exp_q.push_back(r[7:0]);
    end
    append_fcs();
    frame_q = exp_q;
endfunction

// node plus one, slot byte swapped, fcs over what goes out
function automatic void build_expected(int slot, logic [7:0] data);
    exp_q = frame_q;
    repeat (4) void'(exp_q.pop_back());
    exp_q[11] = exp_q[11] + 8'd1;
    if (12 + slot < exp_q.size()) begin
        exp_q[12 + slot] = data;
    end
    append_fcs();
endfunction

`endif

//--- sim/tb_ring_node.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ring_node;

    localparam int KIND_GOOD         = 0;
    localparam int KIND_NO_SLOT      = 1;
    localparam int KIND_BAD_FCS      = 2;
    localparam int KIND_BAD_FIRST    = 3;
    localparam int KIND_BAD_PREAMBLE = 4;
    localparam int KIND_EARLY_LAST   = 5;

    logic        clk;
    logic        reset;
    logic        rx_first;
    logic        rx_last;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        tx_first;
    logic        tx_last;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        rx_start;
    logic        rx_end;
    logic        rx_error;
    logic [15:0] rx_length;
    logic [7:0]  rx_type;
    logic [7:0]  rx_node;
    logic        payload_first;
    logic        payload_last;
    logic [15:0] payload_pos;
    logic [7:0]  payload_data;
    logic        payload_valid;
    logic [15:0] slot_pos;
    logic [7:0]  slot_tx_data;
    logic [7:0]  slot_rx_data;
    logic        slot_rx_valid;

    logic [7:0]  frame_q[$];
    logic [7:0]  exp_q[$];
    logic [31:0] rng_state;
    logic [7:0]  exp_slot_rx;
    int          cur_len;
    int          tx_idx;
    int          pay_idx;
    int          start_cnt;
    int          end_cnt;
    int          err_cnt;
    int          slot_cnt;

    `include "tb_frame_model.svh"

    ring_node dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    assert property (@(posedge clk) disable iff (reset) !(rx_end && rx_error))
        else report_failure("rx_end and rx_error pulsed in the same cycle");

    // --------------------
    // output monitor
    // --------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (rx_start) start_cnt++;
            if (rx_end) end_cnt++;
            if (rx_error) err_cnt++;
            if (slot_rx_valid) begin
                slot_cnt++;
                assert (slot_rx_data == exp_slot_rx)
                    else report_mismatch("slot_rx_data", 32'(exp_slot_rx), 32'(slot_rx_data));
            end
            if (payload_valid) begin
                assert (payload_pos == 16'(pay_idx))
                    else report_mismatch("payload_pos", 32'(pay_idx), 32'(payload_pos));
                assert (payload_data == frame_q[12 + pay_idx])
                    else report_mismatch("payload_data", 32'(frame_q[12 + pay_idx]),
                                         32'(payload_data));
                assert (payload_first == (pay_idx == 0))
                    else report_mismatch("payload_first", 32'(pay_idx == 0), 32'(payload_first));
                assert (payload_last == (pay_idx == cur_len))
                    else report_mismatch("payload_last", 32'(pay_idx == cur_len),
                                         32'(payload_last));
                pay_idx++;
            end
            if (tx_valid) begin
                assert (tx_idx < exp_q.size())
                    else report_failure("tx_valid high with no byte left to forward");
                assert (tx_data == exp_q[tx_idx])
                    else report_mismatch("tx_data", 32'(exp_q[tx_idx]), 32'(tx_data));
                assert (tx_first == (tx_idx == 0))
                    else report_mismatch("tx_first", 32'(tx_idx == 0), 32'(tx_first));
                assert (tx_last == (tx_idx == exp_q.size() - 1))
                    else report_mismatch("tx_last", 32'(tx_idx == exp_q.size() - 1), 32'(tx_last));
                tx_idx++;
            end
        end
    end

    // random one-cycle gaps in valid
    task automatic send_frame(int last_at);
        for (int i = 0; i <= last_at; i++) begin
            if (next_rand() % 4 == 0) begin
                @(posedge clk);
                #1 rx_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            rx_valid = 1'b1;
            rx_first = (i == 0);
            rx_last  = (i == last_at);
            rx_data  = frame_q[i];
        end
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        rx_first = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic run_case(int kind, int len);
        logic [31:0] r;
        logic [7:0]  typ;
        logic [7:0]  node;
        int          slot;
        int          last_at;
        int          timeout;
        int          exp_pay;
        bit          fcs_ok;
        r = next_rand();
        typ = r[7:0];
        node = r[15:8];
        build_frame(16'(len), typ, node);
        fcs_ok = (kind == KIND_GOOD || kind == KIND_NO_SLOT || kind == KIND_BAD_FCS);
        if (kind == KIND_NO_SLOT) begin
            slot = len + 3;
        end else if (fcs_ok) begin
            slot = int'(next_rand() % (len + 1));
        end else begin
            slot = 16'hffff;
        end
        build_expected(slot, r[23:16]);
        exp_slot_rx = (slot <= len) ? frame_q[12 + slot] : 8'h00;
        last_at = frame_q.size() - 1;
        exp_pay = fcs_ok ? len + 1 : 0;

        case (kind)
            KIND_BAD_FCS: frame_q[last_at] = frame_q[last_at] ^ 8'h5a;
            KIND_BAD_FIRST: begin
                frame_q[0] = 8'h54;
                exp_q.delete();
            end
            KIND_BAD_PREAMBLE: begin
                frame_q[4] = 8'h57;
                exp_q = exp_q[0:3];
                exp_q.push_back(8'h00);
            end
            KIND_EARLY_LAST: begin
                // cut at payload position 3
                last_at = 15;
                exp_pay = 4;
                exp_q = exp_q[0:14];
                exp_q.push_back(8'h00);
            end
            default: ;
        endcase

        @(posedge clk);
        #1;
        slot_pos = 16'(slot);
        slot_tx_data = r[23:16];
        cur_len = len;
        tx_idx = 0;
        pay_idx = 0;
        start_cnt = 0;
        end_cnt = 0;
        err_cnt = 0;
        slot_cnt = 0;

        send_frame(last_at);

        timeout = 0;
        while (!(tx_idx == exp_q.size() && end_cnt + err_cnt > 0)) begin
            @(posedge clk);
            timeout++;
            if (timeout > 3000) begin
                report_failure("timeout waiting for the frame to pass the node");
            end
        end
        repeat (20) @(posedge clk);

        assert (start_cnt == (kind == KIND_BAD_FIRST ? 0 : 1))
            else report_mismatch("rx_start count", 32'(kind != KIND_BAD_FIRST), 32'(start_cnt));
        assert (end_cnt == (kind == KIND_GOOD || kind == KIND_NO_SLOT ? 1 : 0))
            else report_mismatch("rx_end count", 32'(kind <= KIND_NO_SLOT), 32'(end_cnt));
        assert (err_cnt == (kind == KIND_GOOD || kind == KIND_NO_SLOT ? 0 : 1))
            else report_mismatch("rx_error count", 32'(kind > KIND_NO_SLOT), 32'(err_cnt));
        assert (slot_cnt == (fcs_ok && slot <= len ? 1 : 0))
            else report_mismatch("slot_rx_valid count", 32'(fcs_ok && slot <= len),
                                 32'(slot_cnt));
        assert (pay_idx == exp_pay)
            else report_mismatch("payload_valid count", 32'(exp_pay), 32'(pay_idx));
        if (fcs_ok || kind == KIND_EARLY_LAST) begin
            assert (rx_length == 16'(len))
                else report_mismatch("rx_length", 32'(len), 32'(rx_length));
            assert (rx_type == typ)
                else report_mismatch("rx_type", 32'(typ), 32'(rx_type));
            assert (rx_node == node)
                else report_mismatch("rx_node", 32'(node), 32'(rx_node));
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rng_state = 32'd24348;
        reset = 1'b1;
        rx_first = 1'b0;
        rx_last = 1'b0;
        rx_data = 8'h00;
        rx_valid = 1'b0;
        slot_pos = 16'd0;
        slot_tx_data = 8'h00;
        exp_slot_rx = 8'h00;
        cur_len = 0;
        tx_idx = 0;
        pay_idx = 0;
        start_cnt = 0;
        end_cnt = 0;
        err_cnt = 0;
        slot_cnt = 0;

        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        assert (!rx_start && !rx_end && !rx_error && !payload_valid && !slot_rx_valid && !tx_valid)
            else report_failure("status outputs not low after reset");

        run_case(KIND_GOOD, 0);
        for (int n = 0; n < 8; n++) begin
            run_case(KIND_GOOD, int'(next_rand() % 48));
        end
        run_case(KIND_NO_SLOT, 10);
        run_case(KIND_BAD_FCS, 17);
        run_case(KIND_BAD_FIRST, 8);
        run_case(KIND_GOOD, 5);
        run_case(KIND_BAD_PREAMBLE, 12);
        run_case(KIND_GOOD, 9);
        run_case(KIND_EARLY_LAST, 20);
        run_case(KIND_GOOD, 30);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
